// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
TOP        := tb_periph_top
DUT_TOP    := periph_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
rtl/soc_pkg.sv
rtl/syscon_timer.sv
rtl/syscon_regs.sv
rtl/boot_rom.sv
rtl/wb_periph_decode.sv
rtl/periph_top.sv
tb/tb_periph_top.sv

// File: rtl/boot_rom.hex
// One 32-bit word per line in hex, word 0 first
B0070000
B0070001
B0070002
B0070003
B0070004
B0070005
B0070006
B0070007
B0070008
B0070009
B007000A
B007000B
B007000C
B007000D
B007000E
B007000F

// File: rtl/boot_rom.sv
//****************************************
// Boot ROM on the Wishbone bus
// Image comes from the hex file, rest reads zero
//****************************************

`timescale 1ns/1ps
`default_nettype none

module boot_rom (
   input  wire                     i_clk,
   input  wire                     i_rst_n,
   input  wire  soc_pkg::wb_req_t  i_wb,
   output soc_pkg::wb_rsp_t        o_wb
);

   import soc_pkg::*;

   logic [DATA_W-1:0] mem [ROM_WORDS];
   logic [DATA_W-1:0] rdt_q;
   logic              ack_q;
   logic              acc;

   // Zero fill first so words past the image are defined
   initial begin
      for (int i = 0; i < ROM_WORDS; i++) begin
         mem[i] = '0;
      end
      $readmemh("rtl/boot_rom.hex", mem);
   end

   assign acc = i_wb.cyc && i_wb.stb && !ack_q;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc;
      end
   end

   // Writes are acked but never stored
   always_ff @(posedge i_clk) begin
      if (acc) begin
         rdt_q <= mem[i_wb.adr[$clog2(ROM_SIZE)-1:2]];
      end
   end

   assign o_wb = '{rdt: rdt_q, ack: ack_q, err: 1'b0};

   // Ack belongs to a strobed request that is still held unchanged
   a_ack_after_stb : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_wb.ack |-> $past(i_wb.cyc && i_wb.stb) && i_wb.stb && $stable(i_wb.adr));

endmodule

`default_nettype wire

// File: rtl/periph_top.sv
//****************************************
// Peripheral subsystem top level
// Wishbone slave port, boot ROM and syscon
//****************************************

`timescale 1ns/1ps
`default_nettype none

module periph_top (
   input  wire                          i_clk,
   input  wire                          i_rst_n,
   input  wire  soc_pkg::wb_req_t       i_wb,
   output soc_pkg::wb_rsp_t             o_wb,
   input  wire  [soc_pkg::GPIO_W-1:0]   i_gpio,
   output logic [soc_pkg::GPIO_W-1:0]   o_gpio,
   input  wire                          i_ram_init_done,
   input  wire                          i_ram_init_error,
   output soc_pkg::irq_t                o_irq,
   output logic                         o_nmi_int,
   output logic [soc_pkg::DATA_W-1:0]   o_nmi_vec
);

   import soc_pkg::*;

   wb_req_t rom_req;
   wb_rsp_t rom_rsp;
   wb_req_t sys_req;
   wb_rsp_t sys_rsp;

   wb_periph_decode decode0 (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_wb      (i_wb),
      .o_wb      (o_wb),
      .o_rom_req (rom_req),
      .i_rom_rsp (rom_rsp),
      .o_sys_req (sys_req),
      .i_sys_rsp (sys_rsp)
   );

   boot_rom rom0 (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_wb    (rom_req),
      .o_wb    (rom_rsp)
   );

   syscon_regs syscon0 (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_wb             (sys_req),
      .o_wb             (sys_rsp),
      .i_gpio           (i_gpio),
      .o_gpio           (o_gpio),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .o_irq            (o_irq),
      .o_nmi_int        (o_nmi_int),
      .o_nmi_vec        (o_nmi_vec)
   );

endmodule

`default_nettype wire

// File: rtl/soc_pkg.sv
//****************************************
// Shared definitions for the peripheral side
// Memory map, register offsets, bus and IRQ structs
// Imported by every RTL module and the testbench
//****************************************

`default_nettype none

package soc_pkg;

   // Bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int SEL_W  = DATA_W / 8;
   localparam int GPIO_W = 32;

   // Boot ROM, 4 KiB of 32-bit words
   localparam int ROM_SIZE  = 4096;
   localparam int ROM_WORDS = ROM_SIZE / 4;

   // Targets are picked by address bits 15:12
   localparam logic [3:0] REGION_ROM    = 4'h0;
   localparam logic [3:0] REGION_SYSCON = 4'h1;

   localparam logic [DATA_W-1:0] SYSCON_VERSION = 32'h0001_0300;

   //****************************************
   // System controller byte offsets
   //****************************************
   localparam logic [5:0] REG_VERSION  = 6'h00;
   localparam logic [5:0] REG_STATUS   = 6'h04;
   localparam logic [5:0] REG_GPIO_IN  = 6'h08;
   localparam logic [5:0] REG_GPIO_OUT = 6'h0C;
   localparam logic [5:0] REG_SW_IRQ   = 6'h10;
   localparam logic [5:0] REG_NMI_VEC  = 6'h14;
   localparam logic [5:0] REG_NMI_TRIG = 6'h18;
   localparam logic [5:0] REG_MTIME    = 6'h20;
   localparam logic [5:0] REG_MTIMECMP = 6'h24;

   // Timer stays quiet until software programs a compare value
   localparam logic [DATA_W-1:0] MTIMECMP_RESET = '1;

   //****************************************
   // Bus and interrupt types
   //****************************************
   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdt;
      logic              ack;
      logic              err;
   } wb_rsp_t;

   // Same order as the core's external interrupt sources
   typedef struct packed {
      logic timer;
      logic sw3;
      logic sw4;
   } irq_t;

   // Merge a write word into a register under the byte enables
   function automatic logic [DATA_W-1:0] wr_bytes(input logic [DATA_W-1:0] old_val,
                                                  input logic [DATA_W-1:0] new_val,
                                                  input logic [SEL_W-1:0]  sel);
      logic [DATA_W-1:0] res;
      res = old_val;
      for (int b = 0; b < SEL_W; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// File: rtl/syscon_regs.sv
//****************************************
// System controller register file
// Version, RAM init status, GPIO, soft IRQs,
// NMI vector and trigger, machine timer
//****************************************

`timescale 1ns/1ps
`default_nettype none

module syscon_regs (
   input  wire                          i_clk,
   input  wire                          i_rst_n,
   input  wire  soc_pkg::wb_req_t       i_wb,
   output soc_pkg::wb_rsp_t             o_wb,
   input  wire  [soc_pkg::GPIO_W-1:0]   i_gpio,
   output logic [soc_pkg::GPIO_W-1:0]   o_gpio,
   input  wire                          i_ram_init_done,
   input  wire                          i_ram_init_error,
   output soc_pkg::irq_t                o_irq,
   output logic                         o_nmi_int,
   output logic [soc_pkg::DATA_W-1:0]   o_nmi_vec
);

   import soc_pkg::*;

   logic              acc;
   logic              wr;
   logic [3:0]        reg_idx;
   logic              ack_q;
   logic [DATA_W-1:0] rdt_q;
   logic [DATA_W-1:0] rdata;
   logic [1:0]        sw_irq;
   logic              cmp_we;
   logic [DATA_W-1:0] mtime;
   logic [DATA_W-1:0] mtimecmp;
   logic              timer_irq;

   // New access only when no ack is pending
   assign acc     = i_wb.cyc && i_wb.stb && !ack_q;
   assign wr      = acc && i_wb.we;
   assign reg_idx = i_wb.adr[5:2];
   assign cmp_we  = wr && (reg_idx == REG_MTIMECMP[5:2]);

   //****************************************
   // Writable registers
   //****************************************
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_gpio    <= '0;
         sw_irq    <= 2'b00;
         o_nmi_vec <= '0;
      end else if (wr) begin
         case (reg_idx)
            REG_GPIO_OUT[5:2]: o_gpio    <= wr_bytes(o_gpio, i_wb.dat, i_wb.sel);
            REG_NMI_VEC[5:2]:  o_nmi_vec <= wr_bytes(o_nmi_vec, i_wb.dat, i_wb.sel);
            REG_SW_IRQ[5:2]: begin
               // Bit 0 drives sw3, bit 1 drives sw4
               if (i_wb.sel[0]) begin
                  sw_irq <= i_wb.dat[1:0];
               end
            end
            default: ;
         endcase
      end
   end

   // NMI fires the cycle after the trigger write is acked
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_nmi_int <= 1'b0;
      end else begin
         o_nmi_int <= ack_q && i_wb.cyc && i_wb.stb && i_wb.we &&
                      (reg_idx == REG_NMI_TRIG[5:2]);
      end
   end

   //****************************************
   // Read path
   //****************************************
   always_comb begin
      case (reg_idx)
         REG_VERSION[5:2]:  rdata = SYSCON_VERSION;
         REG_STATUS[5:2]:   rdata = {{(DATA_W-2){1'b0}}, i_ram_init_error, i_ram_init_done};
         REG_GPIO_IN[5:2]:  rdata = i_gpio;
         REG_GPIO_OUT[5:2]: rdata = o_gpio;
         REG_SW_IRQ[5:2]:   rdata = {{(DATA_W-2){1'b0}}, sw_irq};
         REG_NMI_VEC[5:2]:  rdata = o_nmi_vec;
         REG_MTIME[5:2]:    rdata = mtime;
         REG_MTIMECMP[5:2]: rdata = mtimecmp;
         default:           rdata = '0;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc;
      end
   end

   always_ff @(posedge i_clk) begin
      if (acc) begin
         rdt_q <= rdata;
      end
   end

   assign o_wb  = '{rdt: rdt_q, ack: ack_q, err: 1'b0};
   assign o_irq = '{timer: timer_irq, sw3: sw_irq[0], sw4: sw_irq[1]};

   syscon_timer timer0 (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_cmp_we    (cmp_we),
      .i_cmp_sel   (i_wb.sel),
      .i_cmp_wdata (i_wb.dat),
      .o_mtime     (mtime),
      .o_mtimecmp  (mtimecmp),
      .o_timer_irq (timer_irq)
   );

   // Trigger decode in the ack cycle needs the request held unchanged
   a_req_held : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      ack_q |-> i_wb.cyc && i_wb.stb && $stable(i_wb.adr) && $stable(i_wb.we));

endmodule

`default_nettype wire

// File: rtl/syscon_timer.sv
//****************************************
// Machine timer for the system controller
// Free-running count, compare register, IRQ level
//****************************************

`timescale 1ns/1ps
`default_nettype none

module syscon_timer (
   input  wire                         i_clk,
   input  wire                         i_rst_n,
   input  wire                         i_cmp_we,
   input  wire  [soc_pkg::SEL_W-1:0]   i_cmp_sel,
   input  wire  [soc_pkg::DATA_W-1:0]  i_cmp_wdata,
   output logic [soc_pkg::DATA_W-1:0]  o_mtime,
   output logic [soc_pkg::DATA_W-1:0]  o_mtimecmp,
   output logic                        o_timer_irq
);

   import soc_pkg::*;

   // Counts every cycle and wraps
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_mtime <= '0;
      end else begin
         o_mtime <= o_mtime + 1'b1;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_mtimecmp <= MTIMECMP_RESET;
      end else if (i_cmp_we) begin
         o_mtimecmp <= wr_bytes(o_mtimecmp, i_cmp_wdata, i_cmp_sel);
      end
   end

   // Level stays up until software moves the compare past the count
   assign o_timer_irq = (o_mtime >= o_mtimecmp);

endmodule

`default_nettype wire

// File: rtl/wb_periph_decode.sv
//****************************************
// Wishbone address decoder for the peripherals
// Steers each request to the ROM or the syscon
// and errors out unmapped addresses
//****************************************

`timescale 1ns/1ps
`default_nettype none

module wb_periph_decode (
   input  wire                     i_clk,
   input  wire                     i_rst_n,
   input  wire  soc_pkg::wb_req_t  i_wb,
   output soc_pkg::wb_rsp_t        o_wb,
   output soc_pkg::wb_req_t        o_rom_req,
   input  wire  soc_pkg::wb_rsp_t  i_rom_rsp,
   output soc_pkg::wb_req_t        o_sys_req,
   input  wire  soc_pkg::wb_rsp_t  i_sys_rsp
);

   import soc_pkg::*;

   logic [3:0] region;
   logic       rom_sel;
   logic       sys_sel;
   logic       err_q;

   assign region  = i_wb.adr[15:12];
   assign rom_sel = (region == REGION_ROM);
   assign sys_sel = (region == REGION_SYSCON);

   // Only the selected target sees a strobe
   always_comb begin
      o_rom_req     = i_wb;
      o_rom_req.stb = i_wb.stb && rom_sel;
      o_sys_req     = i_wb;
      o_sys_req.stb = i_wb.stb && sys_sel;
   end

   // One-cycle error for holes in the map
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         err_q <= 1'b0;
      end else begin
         err_q <= i_wb.cyc && i_wb.stb && !rom_sel && !sys_sel && !err_q;
      end
   end

   // Request is held until the response, so the select is still valid here
   always_comb begin
      if (rom_sel) begin
         o_wb = i_rom_rsp;
      end else if (sys_sel) begin
         o_wb = i_sys_rsp;
      end else begin
         o_wb = '{rdt: '0, ack: 1'b0, err: err_q};
      end
   end

   // No target may ack while the decoder flags an error
   a_ack_err_excl : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(err_q && (i_rom_rsp.ack || i_sys_rsp.ack)));

endmodule

`default_nettype wire

// File: tb/tb_periph_top.sv
//****************************************
// Random-stimulus testbench for periph_top
// Wishbone master plus a model of the ROM image
// and the system controller register map
//****************************************

`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;

   import soc_pkg::*;

   localparam int CLK_HALF    = 10;
   localparam int DRV_DLY     = 1;
   localparam int BUS_TIMEOUT = 8;
   localparam int IRQ_TIMEOUT = 200;
   localparam int N_ROM_RD    = 64;
   localparam int N_ROM_WR    = 16;
   localparam int N_REG       = 48;
   localparam int N_ERR       = 16;

   logic              clk;
   logic              rst_n;
   wb_req_t           wb_req;
   wb_rsp_t           wb_rsp;
   logic [GPIO_W-1:0] gpio_in;
   logic [GPIO_W-1:0] gpio_out;
   logic              ram_done;
   logic              ram_err;
   irq_t              irq;
   logic              nmi_int;
   logic [DATA_W-1:0] nmi_vec;

   logic [31:0]       rng;
   int                errors;
   int                test_num;
   int                tests_failed;
   int                errs_at_start;
   logic              nmi_at_ack;
   logic              nmi_after_ack;

   // Model copies of the writable registers
   logic [GPIO_W-1:0] m_gpio;
   logic [1:0]        m_sw;
   logic [DATA_W-1:0] m_nmi_vec;

   periph_top dut0 (
      .i_clk            (clk),
      .i_rst_n          (rst_n),
      .i_wb             (wb_req),
      .o_wb             (wb_rsp),
      .i_gpio           (gpio_in),
      .o_gpio           (gpio_out),
      .i_ram_init_done  (ram_done),
      .i_ram_init_error (ram_err),
      .o_irq            (irq),
      .o_nmi_int        (nmi_int),
      .o_nmi_vec        (nmi_vec)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // xorshift32
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Image words count up from B0070000, rest of the ROM is zero
   function automatic logic [31:0] rom_word(input int idx);
      if (idx < 16) begin
         return 32'hB007_0000 + 32'(idx);
      end
      return 32'h0;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  sel);
      logic [31:0] mask;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      return (old_val & ~mask) | (new_val & mask);
   endfunction

   function automatic logic [ADDR_W-1:0] sys_adr(input logic [5:0] off);
      return {REGION_SYSCON, 6'h00, off};
   endfunction

   task automatic report_error(input string msg);
      $display("error at %0d ns: %s", $time, msg);
      errors++;
   endtask

   task automatic start_test();
      test_num++;
      errs_at_start = errors;
   endtask

   task automatic end_test(input string name);
      if (errors == errs_at_start) begin
         $display("test %0d %s: passed", test_num, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", test_num, name, errors - errs_at_start);
         tests_failed++;
      end
   endtask

   //****************************************
   // Wishbone classic master
   //****************************************
   task automatic bus_access(input logic [ADDR_W-1:0] adr, input logic we,
                             input logic [31:0] dat, input logic [3:0] sel,
                             output logic [31:0] rdt, output logic got_ack,
                             output logic got_err);
      int waited;
      got_ack = 1'b0;
      got_err = 1'b0;
      rdt     = '0;
      waited  = 0;
      wb_req  = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      while (!got_ack && !got_err && waited < BUS_TIMEOUT) begin
         @(posedge clk);
         #DRV_DLY;
         waited++;
         if (wb_rsp.ack || wb_rsp.err) begin
            got_ack    = wb_rsp.ack;
            got_err    = wb_rsp.err;
            rdt        = wb_rsp.rdt;
            nmi_at_ack = nmi_int;
         end
      end
      if (!got_ack && !got_err) begin
         $display("timeout: no ack or err for address %h after %0d cycles", adr, BUS_TIMEOUT);
         errors++;
      end else if (waited != 1) begin
         report_error($sformatf("response for %h took %0d cycles", adr, waited));
      end
      // Cycle closes on the edge that samples the response
      @(posedge clk);
      #DRV_DLY;
      nmi_after_ack = nmi_int;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
      // Idle cycle before the next request
      @(posedge clk);
      #DRV_DLY;
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [31:0] rdt);
      logic ack;
      logic err;
      bus_access(adr, 1'b0, 32'h0, 4'hF, rdt, ack, err);
      if (ack !== 1'b1 || err !== 1'b0) report_error($sformatf("read of %h not acked", adr));
   endtask

   task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      logic [31:0] rdt;
      logic        ack;
      logic        err;
      bus_access(adr, 1'b1, dat, sel, rdt, ack, err);
      if (ack !== 1'b1 || err !== 1'b0) report_error($sformatf("write to %h not acked", adr));
   endtask

   //****************************************
   // Test sequence
   //****************************************
   initial begin
      logic [31:0]       r;
      logic [31:0]       d;
      logic [31:0]       rd;
      logic [31:0]       t;
      logic [31:0]       cmp;
      logic [3:0]        sel;
      logic [ADDR_W-1:0] adr;
      logic              ack;
      logic              err;
      int                idx;
      int                waited;

      rng           = 32'h9483_89a7;
      errors        = 0;
      test_num      = 0;
      tests_failed  = 0;
      errs_at_start = 0;
      nmi_at_ack    = 1'b0;
      nmi_after_ack = 1'b0;
      m_gpio        = '0;
      m_sw          = 2'b00;
      m_nmi_vec     = '0;
      rst_n         = 1'b0;
      wb_req        = '0;
      gpio_in       = '0;
      ram_done      = 1'b0;
      ram_err       = 1'b0;
      repeat (3) @(posedge clk);
      #DRV_DLY;
      rst_n = 1'b1;

      start_test();
      if (irq !== 3'b000) report_error($sformatf("o_irq is %b after reset", irq));
      if (nmi_int !== 1'b0) report_error("o_nmi_int high after reset");
      if (gpio_out !== '0) report_error($sformatf("o_gpio is %h after reset", gpio_out));
      if (nmi_vec !== '0) report_error($sformatf("o_nmi_vec is %h after reset", nmi_vec));
      if (wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0) report_error("ack or err after reset");
      bus_read(sys_adr(REG_MTIMECMP), rd);
      if (rd !== 32'hFFFF_FFFF) report_error($sformatf("mtimecmp reset value %h", rd));
      end_test("reset state");

      start_test();
      // Sweep the image and its edge, then random words
      for (int i = 0; i < N_ROM_RD + 18; i++) begin
         idx = (i < 18) ? i : int'(next_rand() & 32'h3FF);
         bus_read({REGION_ROM, 10'(idx), 2'b00}, rd);
         if (rd !== rom_word(idx))
            report_error($sformatf("rom word %0d read %h, expected %h", idx, rd, rom_word(idx)));
      end
      for (int i = 0; i < N_ROM_WR; i++) begin
         r   = next_rand();
         idx = (i < N_ROM_WR / 2) ? int'(r[3:0]) : int'(r[9:0]);
         adr = {REGION_ROM, 10'(idx), 2'b00};
         bus_write(adr, next_rand(), r[13:10]);
         bus_read(adr, rd);
         if (rd !== rom_word(idx))
            report_error($sformatf("rom word %0d reads %h after a write to %h", idx, rd, adr));
      end
      end_test("boot rom");

      start_test();
      for (int i = 0; i < N_REG; i++) begin
         r   = next_rand();
         d   = next_rand();
         sel = r[7:4];
         case (r % 32'd3)
            32'd0: begin
               bus_write(sys_adr(REG_GPIO_OUT), d, sel);
               m_gpio = merge_bytes(m_gpio, d, sel);
            end
            32'd1: begin
               bus_write(sys_adr(REG_SW_IRQ), d, sel);
               if (sel[0]) m_sw = d[1:0];
            end
            default: begin
               bus_write(sys_adr(REG_NMI_VEC), d, sel);
               m_nmi_vec = merge_bytes(m_nmi_vec, d, sel);
            end
         endcase
         if (nmi_after_ack !== 1'b0) report_error("o_nmi_int pulsed on a register write");
         bus_read(sys_adr(REG_GPIO_OUT), rd);
         if (rd !== m_gpio) report_error($sformatf("gpio_out read %h, expected %h", rd, m_gpio));
         bus_read(sys_adr(REG_SW_IRQ), rd);
         if (rd !== {30'd0, m_sw}) report_error($sformatf("sw_irq read %h, expected %b", rd, m_sw));
         bus_read(sys_adr(REG_NMI_VEC), rd);
         if (rd !== m_nmi_vec)
            report_error($sformatf("nmi_vec read %h, expected %h", rd, m_nmi_vec));
         if (gpio_out !== m_gpio)
            report_error($sformatf("o_gpio is %h, expected %h", gpio_out, m_gpio));
         if (nmi_vec !== m_nmi_vec) report_error($sformatf("o_nmi_vec is %h", nmi_vec));
         if (irq.sw3 !== m_sw[0] || irq.sw4 !== m_sw[1])
            report_error($sformatf("sw4/sw3 are %b%b, expected %b", irq.sw4, irq.sw3, m_sw));
         gpio_in  = next_rand();
         t        = next_rand();
         ram_done = t[0];
         ram_err  = t[1];
         bus_read(sys_adr(REG_GPIO_IN), rd);
         if (rd !== gpio_in) report_error($sformatf("gpio_in read %h, expected %h", rd, gpio_in));
         bus_read(sys_adr(REG_STATUS), rd);
         if (rd !== {30'd0, ram_err, ram_done}) report_error($sformatf("status read %h", rd));
         bus_read(sys_adr(REG_VERSION), rd);
         if (rd !== SYSCON_VERSION) report_error($sformatf("version read %h", rd));
      end
      bus_read(sys_adr(REG_NMI_TRIG), rd);
      if (rd !== 32'h0) report_error($sformatf("nmi_trig read %h, expected zero", rd));
      bus_read(sys_adr(6'h3C), rd);
      if (rd !== 32'h0) report_error($sformatf("unmapped offset read %h, expected zero", rd));
      end_test("register map");

      start_test();
      for (int i = 0; i < 3; i++) begin
         if (nmi_int !== 1'b0) report_error("o_nmi_int high before the trigger write");
         bus_write(sys_adr(REG_NMI_TRIG), next_rand(), 4'hF);
         if (nmi_at_ack !== 1'b0) report_error("o_nmi_int high during the ack cycle");
         if (nmi_after_ack !== 1'b1) report_error("o_nmi_int low in the cycle after ack");
         if (nmi_int !== 1'b0) report_error("o_nmi_int high for more than one cycle");
      end
      end_test("nmi pulse");

      start_test();
      bus_read(sys_adr(REG_MTIME), rd);
      cmp = rd + 32'd40;
      bus_write(sys_adr(REG_MTIMECMP), cmp, 4'hF);
      if (irq.timer !== 1'b0) report_error("timer interrupt high right after the compare write");
      bus_read(sys_adr(REG_MTIMECMP), rd);
      if (rd !== cmp) report_error($sformatf("mtimecmp read %h, expected %h", rd, cmp));
      waited = 0;
      while (irq.timer !== 1'b1 && waited < IRQ_TIMEOUT) begin
         @(posedge clk);
         #DRV_DLY;
         waited++;
      end
      if (irq.timer !== 1'b1) begin
         $display("timeout: timer interrupt did not rise within %0d cycles", IRQ_TIMEOUT);
         errors++;
      end else begin
         for (int i = 0; i < 4; i++) begin
            bus_read(sys_adr(REG_MTIME), rd);
            if (rd < cmp) report_error($sformatf("mtime %h below compare %h", rd, cmp));
         end
      end
      end_test("machine timer");

      start_test();
      for (int i = 0; i < N_ERR; i++) begin
         r   = next_rand();
         t   = 32'd2 + (r % 32'd14);
         adr = {t[3:0], r[15:4]};
         bus_access(adr, r[16], next_rand(), 4'hF, rd, ack, err);
         if (err !== 1'b1) report_error($sformatf("no err for unmapped address %h", adr));
         if (ack !== 1'b0) report_error($sformatf("ack for unmapped address %h", adr));
         if (rd !== 32'h0) report_error($sformatf("err data %h for address %h", rd, adr));
      end
      end_test("bus errors");

      $display("%0d tests run, %0d failed, %0d errors", test_num, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
